// File: design/cab_adc.sv
/* Cabinet ADC model: samples the host analog words on a latch strobe and maps
   them to the wheel, gas and brake bytes the game expects for each controller. */
`timescale 1ns/1ps
`default_nettype none

module cab_adc import hangon_cab_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        latch,
    input  adc_ch_t     adc_ch,
    input  ctrl_type_t  ctrl_type,
    input  cab_byte_t   joystick1,
    input  logic [15:0] joyana1,
    input  logic [15:0] joyana1b,
    output cab_byte_t   adc_byte
);

    logic [15:0] ana1;
    logic [15:0] ana1b;
    cab_byte_t   gas_byte;
    cab_byte_t   brake_byte;
    cab_byte_t   wheel_byte;

    // Negative half of a stick axis, pushed further reads larger
    function automatic cab_byte_t stick_neg(input logic [15:0] w);
        stick_neg = w[15] ? ~{w[14:8], w[14]} : 8'h00;
    endfunction

    // Positive half of a stick axis
    function automatic cab_byte_t stick_pos(input logic [15:0] w);
        stick_pos = w[15] ? 8'h00 : {w[14:8], w[14]};
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            ana1  <= '0;
            ana1b <= '0;
        end else if (latch) begin
            ana1  <= joyana1;
            ana1b <= joyana1b;
        end
    end

    always_comb begin
        wheel_byte = ~ana1[7:0] ^ 8'h80;  // Centre reads 80
        if (!joystick1[1]) wheel_byte = WHEEL_LEFT_BYTE;
        if (!joystick1[0]) wheel_byte = WHEEL_RIGHT_BYTE;

        case (ctrl_type)
            CTRL_DUAL_STICK: gas_byte = stick_neg(ana1b);
            CTRL_TRIGGER:    gas_byte = ana1b[7] ? 8'h00 : {ana1b[6:0], ana1b[6]};
            CTRL_WHEEL:      gas_byte = stick_neg(ana1);   // Pedal on the wheel Y axis
            default:         gas_byte = 8'h00;
        endcase
        if (!joystick1[4]) gas_byte = FULL_BYTE;

        case (ctrl_type)
            CTRL_DUAL_STICK, CTRL_TRIGGER: brake_byte = stick_pos(ana1b);
            CTRL_WHEEL:                    brake_byte = stick_neg(ana1b);
            default:                       brake_byte = 8'h00;
        endcase
        if (!joystick1[5]) brake_byte = FULL_BYTE;
    end

    always_comb begin
        case (adc_ch)
            ADC_WHEEL: adc_byte = wheel_byte;
            ADC_GAS:   adc_byte = gas_byte;
            ADC_BRAKE: adc_byte = brake_byte;
            default:   adc_byte = FULL_BYTE;  // Unconnected inputs
        endcase
    end

endmodule

`default_nettype wire

// File: design/cab_io.sv
/* Second pipeline stage: cabinet I/O port. Reads are combinational from io_cs,
   control writes latch on the lower byte lane. */
`timescale 1ns/1ps
`default_nettype none

module cab_io import hangon_bus_pkg::*, hangon_cab_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       io_cs,
    input  bus_addr_t  addr,
    input  logic       rnw,
    input  logic [1:0] dsn,
    input  bus_word_t  cpu_dout,
    input  cab_byte_t  joystick1,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  cab_byte_t  dipsw_a,
    input  cab_byte_t  dipsw_b,
    input  bus_word_t  joyana1,
    input  bus_word_t  joyana1b,
    input  ctrl_type_t ctrl_type,
    output cab_byte_t  cab_dout,
    output logic       video_en,
    output logic       mute,
    output logic       snd_rstb
);

    logic [2:0] io_sub;
    logic       lds_wr;   // Write on the low byte lane
    logic       adc_latch;
    adc_ch_t    adc_ch;
    cab_byte_t  adc_byte;

    assign io_sub    = {addr[13], addr[12], addr[5]};
    assign lds_wr    = io_cs && !rnw && !dsn[0];
    assign adc_latch = io_cs && !rnw && io_sub == IO_ADC;  // Starts a conversion

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            adc_ch   <= '0;
            video_en <= 1'b1;
            mute     <= 1'b0;
            snd_rstb <= 1'b1;
        end else if (lds_wr) begin
            case (io_sub)
                IO_CTRL_WR: begin
                    adc_ch   <= {1'b0, cpu_dout[7:6]};
                    video_en <= cpu_dout[4];
                    mute     <= ~cpu_dout[5];  // Darlington driver inverts
                end
                IO_SND_WR: snd_rstb <= cpu_dout[0];
                default: ;
            endcase
        end
    end

    always_comb begin
        cab_dout = FULL_BYTE;
        if (io_cs) begin
            case (io_sub)
                IO_INPUTS: begin
                    case (addr[2:1])
                        2'd1: cab_dout = {2'b11, joystick1[7], start_button[0],
                                          service, dip_test, coin_input};
                        2'd2: cab_dout = dipsw_a;
                        2'd3: cab_dout = dipsw_b;
                        default: cab_dout = FULL_BYTE;  // Unused port
                    endcase
                end
                IO_ADC:  cab_dout = adc_byte;
                default: cab_dout = FULL_BYTE;
            endcase
        end
    end

    cab_adc u_adc (
        .clk       (clk),
        .rst       (rst),
        .latch     (adc_latch),
        .adc_ch    (adc_ch),
        .ctrl_type (ctrl_type),
        .joystick1 (joystick1),
        .joyana1   (joyana1),
        .joyana1b  (joyana1b),
        .adc_byte  (adc_byte)
    );

endmodule

`default_nettype wire

// File: design/hangon_bus_pkg.sv
/* Main 68000 bus widths, word types and memory mapper region indices.
   Import into any block that decodes or carries main bus traffic. */
`default_nettype none

package hangon_bus_pkg;

    localparam int BUS_ADDR_W = 23;  // Word address, byte lane from the strobes
    localparam int BUS_DATA_W = 16;

    // Numbered as the CPU pins, bit 0 does not exist on the bus
    typedef logic [BUS_ADDR_W:1]   bus_addr_t;
    typedef logic [BUS_DATA_W-1:0] bus_word_t;

    // Mapper region strobes, the CSS lines on the schematics
    localparam int REG_MEM     = 0;
    localparam int REG_SCR     = 1;
    localparam int REG_PAL     = 2;
    localparam int REG_OBJ     = 3;
    localparam int REG_IO      = 4;
    localparam int REG_SUB     = 5;
    localparam int NUM_REGIONS = 6;

    typedef logic [NUM_REGIONS-1:0] region_t;

    // Interrupt acknowledge cycles select no device
    localparam logic [2:0] FC_INTACK = 3'd7;

    // Pulled-up data bus when no device drives it
    localparam bus_word_t OPEN_BUS = '1;

endpackage

`default_nettype wire

// File: design/hangon_cab_pkg.sv
/* Cabinet I/O map of the Super Hang On main board: sub-addresses, ADC channels,
   controller types and the fixed bytes returned by the input ports. */
`default_nettype none

package hangon_cab_pkg;

    typedef logic [7:0] cab_byte_t;
    typedef logic [2:0] adc_ch_t;
    typedef logic [2:0] ctrl_type_t;

    // Sub-address is {A13, A12, A5} inside the I/O region
    localparam logic [2:0] IO_CTRL_WR = 3'd0;  // Video, mute, ADC channel
    localparam logic [2:0] IO_SND_WR  = 3'd1;  // Sound CPU reset
    localparam logic [2:0] IO_INPUTS  = 3'd2;  // Switches and DIP banks
    localparam logic [2:0] IO_ADC     = 3'd7;  // Read converts, write latches

    // ADC multiplexer inputs
    localparam adc_ch_t ADC_WHEEL = 3'd0;
    localparam adc_ch_t ADC_GAS   = 3'd1;
    localparam adc_ch_t ADC_BRAKE = 3'd2;

    // Host side controller fitted to the cabinet
    localparam ctrl_type_t CTRL_DUAL_STICK = 3'd0;
    localparam ctrl_type_t CTRL_TRIGGER    = 3'd1;
    localparam ctrl_type_t CTRL_WHEEL      = 3'd2;

    // Digital steering overrides the analog wheel
    localparam cab_byte_t WHEEL_LEFT_BYTE  = 8'he0;
    localparam cab_byte_t WHEEL_RIGHT_BYTE = 8'h20;

    // Idle input port and fully pressed pedal
    localparam cab_byte_t FULL_BYTE = 8'hff;

endpackage

`default_nettype wire

// File: design/hangon_main.sv
/* Super Hang On main CPU glue logic. Sits between the CPU and memory mapper and
   the memories: decode, cabinet I/O and read mux in three stages. */
`timescale 1ns/1ps
`default_nettype none

module hangon_main import hangon_bus_pkg::*, hangon_cab_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    // CPU bus request
    input  bus_addr_t  addr,
    input  logic       asn,
    input  logic [2:0] fc,
    input  logic       rnw,
    input  logic [1:0] dsn,
    input  bus_word_t  cpu_dout,
    input  region_t    region_active,  // From the mapper
    // Memories and video
    input  bus_word_t  rom_data,
    input  bus_word_t  ram_data,
    input  bus_word_t  char_dout,
    input  bus_word_t  pal_dout,
    input  bus_word_t  obj_dout,
    input  bus_word_t  sub_din,
    input  logic       rom_ok,
    input  logic       ram_ok,
    input  logic       sub_ok,
    // Cabinet
    input  cab_byte_t  joystick1,
    input  bus_word_t  joyana1,
    input  bus_word_t  joyana1b,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic       service,
    input  logic       dip_test,
    input  cab_byte_t  dipsw_a,
    input  cab_byte_t  dipsw_b,
    input  ctrl_type_t ctrl_type,
    output logic       rom_cs,
    output logic       ram_cs,
    output logic       vram_cs,
    output logic       char_cs,
    output logic       pal_cs,
    output logic       objram_cs,
    output logic       sub_cs,
    output bus_word_t  cpu_din,
    output logic       bus_busy,
    output logic       video_en,
    output logic       mute,
    output logic       snd_rstb
);

    logic      io_cs;
    cab_byte_t cab_dout;

    main_cs_decode u_cs (
        .clk(clk), .rst(rst),
        .addr(addr), .asn(asn), .fc(fc), .dsn(dsn),
        .region_active(region_active),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs), .sub_cs(sub_cs)
    );

    cab_io u_io (
        .clk(clk), .rst(rst),
        .io_cs(io_cs), .addr(addr), .rnw(rnw), .dsn(dsn), .cpu_dout(cpu_dout),
        .joystick1(joystick1), .start_button(start_button), .coin_input(coin_input),
        .service(service), .dip_test(dip_test),
        .dipsw_a(dipsw_a), .dipsw_b(dipsw_b),
        .joyana1(joyana1), .joyana1b(joyana1b), .ctrl_type(ctrl_type),
        .cab_dout(cab_dout), .video_en(video_en), .mute(mute), .snd_rstb(snd_rstb)
    );

    main_data_mux u_mux (
        .clk(clk), .rst(rst),
        .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
        .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs), .sub_cs(sub_cs),
        .cab_dout(cab_dout),
        .rom_data(rom_data), .ram_data(ram_data), .char_dout(char_dout),
        .pal_dout(pal_dout), .obj_dout(obj_dout), .sub_din(sub_din),
        .rom_ok(rom_ok), .ram_ok(ram_ok), .sub_ok(sub_ok),
        .cpu_din(cpu_din), .bus_busy(bus_busy)
    );

endmodule

`default_nettype wire

// File: design/main_cs_decode.sv
/* First pipeline stage: turns the address strobe, function code and mapper
   region strobes into registered chip selects, valid the cycle after the request. */
`timescale 1ns/1ps
`default_nettype none

module main_cs_decode import hangon_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bus_addr_t  addr,
    input  logic       asn,
    input  logic [2:0] fc,
    input  logic [1:0] dsn,
    input  region_t    region_active,
    output logic       rom_cs,
    output logic       ram_cs,
    output logic       vram_cs,
    output logic       char_cs,
    output logic       pal_cs,
    output logic       objram_cs,
    output logic       io_cs,
    output logic       sub_cs
);

    logic bus_req;
    logic ds_active;  // Either byte lane strobed
    logic ram_page;   // Top quarter of the MEM region

    assign bus_req   = !asn && fc != FC_INTACK;
    assign ds_active = !(&dsn);
    assign ram_page  = addr[18:17] == 2'b11;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            sub_cs    <= 1'b0;
        end else if (bus_req) begin
            rom_cs    <= region_active[REG_MEM] && !ram_page;
            ram_cs    <= region_active[REG_MEM] && ram_page && ds_active;
            char_cs   <= region_active[REG_SCR] && addr[16];   // Text layer
            vram_cs   <= region_active[REG_SCR] && !addr[16] && ds_active;
            pal_cs    <= region_active[REG_PAL];
            objram_cs <= region_active[REG_OBJ];
            io_cs     <= region_active[REG_IO];
            sub_cs    <= region_active[REG_SUB];  // Shared with the sub CPU
        end else begin
            // Bus idle or interrupt acknowledge
            rom_cs    <= 1'b0;
            ram_cs    <= 1'b0;
            vram_cs   <= 1'b0;
            char_cs   <= 1'b0;
            pal_cs    <= 1'b0;
            objram_cs <= 1'b0;
            io_cs     <= 1'b0;
            sub_cs    <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: design/main_data_mux.sv
/* Third pipeline stage: registers the CPU read data from the selected device and
   raises bus_busy while a slow memory has not returned its word. */
`timescale 1ns/1ps
`default_nettype none

module main_data_mux import hangon_bus_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       rom_cs,
    input  logic       ram_cs,
    input  logic       vram_cs,
    input  logic       char_cs,
    input  logic       pal_cs,
    input  logic       objram_cs,
    input  logic       io_cs,
    input  logic       sub_cs,
    input  logic [7:0] cab_dout,
    input  bus_word_t  rom_data,
    input  bus_word_t  ram_data,
    input  bus_word_t  char_dout,
    input  bus_word_t  pal_dout,
    input  bus_word_t  obj_dout,
    input  bus_word_t  sub_din,
    input  logic       rom_ok,
    input  logic       ram_ok,
    input  logic       sub_ok,
    output bus_word_t  cpu_din,
    output logic       bus_busy
);

    // Work RAM and VRAM share one SDRAM port
    assign bus_busy = (rom_cs && !rom_ok) ||
                      ((ram_cs || vram_cs) && !ram_ok) ||
                      (sub_cs && !sub_ok);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cpu_din <= '0;
        end else begin
            cpu_din <= (ram_cs || vram_cs) ? ram_data   :
                       rom_cs              ? rom_data   :  // No decryption
                       char_cs             ? char_dout  :
                       pal_cs              ? pal_dout   :
                       objram_cs           ? obj_dout   :
                       sub_cs              ? sub_din    :
                       io_cs               ? {8'hff, cab_dout} :
                                             OPEN_BUS;
        end
    end

endmodule

`default_nettype wire

// File: hangon_main.f
design/hangon_bus_pkg.sv
design/hangon_cab_pkg.sv
design/main_cs_decode.sv
design/cab_adc.sv
design/cab_io.sv
design/main_data_mux.sv
design/hangon_main.sv
verif/tb_clk_gen.sv
verif/hangon_main_sva.sv
verif/tb_hangon_main.sv

// File: run_sim.sh
#!/bin/sh
# Build the hangon_main testbench with Verilator, run it and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_hangon_main \
    -f hangon_main.f

# Result is taken from the log below
./obj_dir/Vtb_hangon_main > sim.log 2>&1 || true
cat sim.log

if grep -q "TB PASSED" sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi

// File: verif/hangon_main_sva.sv
/* Concurrent checks on the read mux stage. Bound into every main_data_mux instance
   so the chip selects, bus_busy and cpu_din are watched in place. */
`timescale 1ns/1ps
`default_nettype none

module hangon_main_sva import hangon_bus_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      rom_cs,
    input logic      ram_cs,
    input logic      vram_cs,
    input logic      char_cs,
    input logic      pal_cs,
    input logic      objram_cs,
    input logic      io_cs,
    input logic      sub_cs,
    input logic      bus_busy,
    input bus_word_t cpu_din
);

    logic [7:0] cs_vec;

    assign cs_vec = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, io_cs, sub_cs};

    // Mapper regions are exclusive, so the selects are too
    a_cs_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(cs_vec))
        else $error("more than one chip select active");

    // Held request while the bus is busy, so the decode must not move
    a_busy_cs: assert property (@(posedge clk) disable iff (rst)
        bus_busy |=> $stable(cs_vec))
        else $error("chip selects changed while bus_busy was high");

    a_din_reset: assert property (@(posedge clk) rst |-> cpu_din == '0)
        else $error("cpu_din not cleared during reset");

endmodule

bind main_data_mux hangon_main_sva u_sva (
    .clk(clk), .rst(rst),
    .rom_cs(rom_cs), .ram_cs(ram_cs), .vram_cs(vram_cs), .char_cs(char_cs),
    .pal_cs(pal_cs), .objram_cs(objram_cs), .io_cs(io_cs), .sub_cs(sub_cs),
    .bus_busy(bus_busy), .cpu_din(cpu_din)
);

`default_nettype wire

// File: verif/tb_clk_gen.sv
/* Testbench clock and reset source: 8 ns clock, reset held for the first 8 rising edges. */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    initial begin
        rst = 1'b1;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

`default_nettype wire

// File: verif/tb_hangon_main.sv
/* Testbench for hangon_main: random bus requests from seed 27 checked against a
   reference model of decode, cabinet I/O, ADC and read mux. Run via run_sim.sh. */
`timescale 1ns/1ps
`default_nettype none

module tb_hangon_main import hangon_bus_pkg::*, hangon_cab_pkg::*; ();

    logic       clk;
    logic       rst;
    bus_addr_t  addr;
    logic       asn;
    logic [2:0] fc;
    logic       rnw;
    logic [1:0] dsn;
    bus_word_t  cpu_dout;
    region_t    region_active;
    bus_word_t  rom_data, ram_data, char_dout, pal_dout, obj_dout, sub_din;
    logic       rom_ok, ram_ok, sub_ok;
    cab_byte_t  joystick1;
    bus_word_t  joyana1, joyana1b;
    logic [1:0] start_button, coin_input;
    logic       service, dip_test;
    cab_byte_t  dipsw_a, dipsw_b;
    ctrl_type_t ctrl_type;
    logic       rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, sub_cs;
    bus_word_t  cpu_din;
    logic       bus_busy, video_en, mute, snd_rstb;
    logic [6:0] cs_ports;

    // Model state of the cabinet registers
    logic        m_video, m_mute, m_snd;
    adc_ch_t     m_adc_ch;
    bus_word_t   m_ana1, m_ana1b;

    int tests;
    int checks;
    int errors;
    int test_err_base;

    assign cs_ports = {rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs, sub_cs};

    tb_clk_gen u_clk (.clk(clk), .rst(rst));

    hangon_main u_dut (.*);

    task automatic check_val(input string name, input logic [15:0] got,
                             input logic [15:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %0d %s: %0d errors", tests, name, errors - test_err_base);
        test_err_base = errors;
    endtask

    task automatic finish_run();
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    endtask

    // Bit order {io, rom, ram, vram, char, pal, obj, sub}
    function automatic logic [7:0] cs_model(input bus_addr_t a, input logic [2:0] f,
                                            input logic [1:0] ds, input region_t r);
        logic [7:0] cs;
        logic       strobe;
        logic       upper_mem;
        cs = 8'd0;
        strobe = ds != 2'b11;
        upper_mem = a[18] && a[17];
        if (f != FC_INTACK) begin
            cs[7] = r[REG_IO];
            cs[6] = r[REG_MEM] && !upper_mem;
            cs[5] = r[REG_MEM] && upper_mem && strobe;
            cs[4] = r[REG_SCR] && !a[16] && strobe;
            cs[3] = r[REG_SCR] && a[16];
            cs[2] = r[REG_PAL];
            cs[1] = r[REG_OBJ];
            cs[0] = r[REG_SUB];
        end
        return cs;
    endfunction

    function automatic logic busy_model(input logic [7:0] cs);
        return (cs[6] && !rom_ok) || ((cs[5] || cs[4]) && !ram_ok) || (cs[0] && !sub_ok);
    endfunction

    function automatic cab_byte_t adc_model();
        cab_byte_t wheel;
        cab_byte_t gas;
        cab_byte_t brake;
        wheel = ~m_ana1[7:0];
        wheel[7] = ~wheel[7];
        if (!joystick1[0]) wheel = WHEEL_RIGHT_BYTE;
        else if (!joystick1[1]) wheel = WHEEL_LEFT_BYTE;
        gas = 8'h00;
        brake = 8'h00;
        case (ctrl_type)
            CTRL_DUAL_STICK: begin
                if (m_ana1b[15]) gas = ~{m_ana1b[14:8], m_ana1b[14]};
                if (!m_ana1b[15]) brake = {m_ana1b[14:8], m_ana1b[14]};
            end
            CTRL_TRIGGER: begin
                if (!m_ana1b[7]) gas = {m_ana1b[6:0], m_ana1b[6]};
                if (!m_ana1b[15]) brake = {m_ana1b[14:8], m_ana1b[14]};
            end
            CTRL_WHEEL: begin
                if (m_ana1[15]) gas = ~{m_ana1[14:8], m_ana1[14]};
                if (m_ana1b[15]) brake = ~{m_ana1b[14:8], m_ana1b[14]};
            end
            default: ;
        endcase
        if (!joystick1[4]) gas = FULL_BYTE;    // Accelerate button
        if (!joystick1[5]) brake = FULL_BYTE;
        case (m_adc_ch)
            ADC_WHEEL: return wheel;
            ADC_GAS:   return gas;
            ADC_BRAKE: return brake;
            default:   return FULL_BYTE;
        endcase
    endfunction

    function automatic cab_byte_t io_read_model(input bus_addr_t a);
        logic [2:0] sub;
        sub = {a[13], a[12], a[5]};
        if (sub == IO_ADC) return adc_model();
        if (sub != IO_INPUTS) return FULL_BYTE;
        case (a[2:1])
            2'd1: return {2'b11, joystick1[7], start_button[0], service, dip_test,
                          coin_input};
            2'd2: return dipsw_a;
            2'd3: return dipsw_b;
            default: return FULL_BYTE;
        endcase
    endfunction

    function automatic bus_word_t mux_model(input logic [7:0] cs, input cab_byte_t cab);
        if (cs[5] || cs[4]) return ram_data;
        if (cs[6]) return rom_data;
        if (cs[3]) return char_dout;
        if (cs[2]) return pal_dout;
        if (cs[1]) return obj_dout;
        if (cs[0]) return sub_din;
        if (cs[7]) return {8'hff, cab};
        return OPEN_BUS;
    endfunction

    function automatic bus_addr_t io_addr(input logic [2:0] sub, input logic [1:0] port);
        bus_addr_t a;
        a = bus_addr_t'($urandom);
        a[13] = sub[2];
        a[12] = sub[1];
        a[5] = sub[0];
        a[2:1] = port;
        return a;
    endfunction

    function automatic region_t rnd_region();
        return region_t'(7'd1 << $urandom_range(6, 0));  // Index 6 selects nothing
    endfunction

    // One CPU bus cycle: request, wait out bus_busy, release asn, check results
    task automatic bus_cycle(input logic rd, input bus_addr_t a, input logic [2:0] f,
                             input logic [1:0] ds, input region_t r, input bus_word_t wdata,
                             input int max_delay);
        logic [7:0] cs_exp;
        bus_word_t  din_exp;
        int         delay;
        int         cycles;
        cs_exp = cs_model(a, f, ds, r);
        delay = $urandom_range(max_delay, 0);
        @(posedge clk);
        addr <= a;
        fc <= f;
        dsn <= ds;
        rnw <= rd;
        region_active <= r;
        cpu_dout <= wdata;
        asn <= 1'b0;
        rom_data <= 16'($urandom);
        ram_data <= 16'($urandom);
        char_dout <= 16'($urandom);
        pal_dout <= 16'($urandom);
        obj_dout <= 16'($urandom);
        sub_din <= 16'($urandom);
        rom_ok <= delay == 0;
        ram_ok <= delay == 0;
        sub_ok <= delay == 0;
        @(posedge clk);  // Request edge, selects register here
        @(negedge clk);
        check_val("chip selects", 16'(cs_ports), 16'(cs_exp[6:0]));
        check_val("bus_busy", 16'(bus_busy), 16'(busy_model(cs_exp)));
        din_exp = mux_model(cs_exp, io_read_model(a));
        cycles = 0;
        while (bus_busy && cycles < 16) begin
            @(posedge clk);
            if (delay > 0) delay--;
            if (delay == 0) begin
                rom_ok <= 1'b1;
                ram_ok <= 1'b1;
                sub_ok <= 1'b1;
            end
            @(negedge clk);
            cycles++;
            check_val("bus_busy", 16'(bus_busy), 16'(busy_model(cs_exp)));
        end
        if (bus_busy) begin
            errors++;
            $display("bus_busy still high after %0d cycles at %0t ns", cycles, $time);
            finish_run();
        end else begin
            @(posedge clk);
            asn <= 1'b1;
            @(negedge clk);
            check_val("cpu_din", cpu_din, din_exp);
            if (!rd && cs_exp[7]) begin
                if (!ds[0] && {a[13], a[12], a[5]} == IO_CTRL_WR) begin
                    m_adc_ch = {1'b0, wdata[7:6]};
                    m_video = wdata[4];
                    m_mute = ~wdata[5];
                end
                if (!ds[0] && {a[13], a[12], a[5]} == IO_SND_WR) m_snd = wdata[0];
                if ({a[13], a[12], a[5]} == IO_ADC) begin
                    m_ana1 = joyana1;
                    m_ana1b = joyana1b;
                end
            end
            check_val("video_en", 16'(video_en), 16'(m_video));
            check_val("mute", 16'(mute), 16'(m_mute));
            check_val("snd_rstb", 16'(snd_rstb), 16'(m_snd));
        end
    endtask

    initial begin
        int         n;
        int         ct;
        int         ch;
        int         cycles;
        logic [2:0] f;
        logic [2:0] sub;
        region_t    io_r;
        void'($urandom(27));
        io_r = '0;
        io_r[REG_IO] = 1'b1;
        tests = 0;
        checks = 0;
        errors = 0;
        test_err_base = 0;
        m_video = 1'b1;
        m_mute = 1'b0;
        m_snd = 1'b1;
        m_adc_ch = '0;
        m_ana1 = '0;
        m_ana1b = '0;
        addr = '0;
        asn = 1'b1;
        fc = 3'd0;
        rnw = 1'b1;
        dsn = 2'b11;
        cpu_dout = '0;
        region_active = '0;
        rom_data = '0;
        ram_data = '0;
        char_dout = '0;
        pal_dout = '0;
        obj_dout = '0;
        sub_din = '0;
        rom_ok = 1'b1;
        ram_ok = 1'b1;
        sub_ok = 1'b1;
        joystick1 = 8'hff;  // Buttons idle high
        joyana1 = '0;
        joyana1b = '0;
        start_button = 2'b11;
        coin_input = 2'b11;
        service = 1'b1;
        dip_test = 1'b1;
        dipsw_a = 8'hff;
        dipsw_b = 8'hff;
        ctrl_type = CTRL_WHEEL;

        @(negedge clk);
        check_val("cpu_din", cpu_din, 16'h0000);
        cycles = 0;
        while (rst && cycles < 40) begin
            @(negedge clk);
            cycles++;
        end
        if (rst) begin
            errors++;
            $display("reset still asserted after %0d cycles", cycles);
            finish_run();
        end else begin
            check_val("chip selects", 16'(cs_ports), 16'h0000);
            check_val("bus_busy", 16'(bus_busy), 16'h0000);
            check_val("video_en", 16'(video_en), 16'h0001);
            check_val("mute", 16'(mute), 16'h0000);
            check_val("snd_rstb", 16'(snd_rstb), 16'h0001);
            end_test("reset values");
        end

        for (n = 0; n < 48; n++) begin
            f = ($urandom_range(3, 0) == 0) ? FC_INTACK : 3'($urandom_range(6, 0));
            bus_cycle(1'b1, bus_addr_t'($urandom), f, 2'($urandom), rnd_region(),
                      16'h0000, 0);
        end
        end_test("chip-select decode");

        for (n = 0; n < 48; n++) begin
            bus_cycle(1'b1, bus_addr_t'($urandom), 3'd5, 2'($urandom), rnd_region(),
                      16'h0000, 6);
        end
        end_test("read mux with back-pressure");

        for (n = 0; n < 32; n++) begin
            @(posedge clk);
            joystick1 <= 8'($urandom);
            start_button <= 2'($urandom);
            coin_input <= 2'($urandom);
            service <= 1'($urandom);
            dip_test <= 1'($urandom);
            dipsw_a <= 8'($urandom);
            dipsw_b <= 8'($urandom);
            bus_cycle(1'b1, io_addr(IO_INPUTS, 2'(n)), 3'd5, 2'b00, io_r, 16'h0000, 0);
        end
        end_test("switch and DIP reads");

        for (n = 0; n < 32; n++) begin
            if ($urandom_range(3, 0) == 0) sub = IO_INPUTS;  // Read-only port
            else sub = ($urandom_range(1, 0) == 0) ? IO_CTRL_WR : IO_SND_WR;
            bus_cycle(1'b0, io_addr(sub, 2'($urandom)), 3'd5, 2'($urandom), io_r,
                      16'($urandom), 0);
        end
        end_test("control writes");

        for (ct = 0; ct < 4; ct++) begin
            for (ch = 0; ch < 4; ch++) begin
                bus_cycle(1'b0, io_addr(IO_CTRL_WR, 2'd0), 3'd5, 2'b00, io_r,
                          {8'h00, 2'(ch), 6'b110000}, 0);
                @(posedge clk);
                joyana1 <= 16'($urandom);
                joyana1b <= 16'($urandom);
                joystick1 <= 8'($urandom) | (($urandom_range(3, 0) != 0) ? 8'h33 : 8'h00);
                ctrl_type <= 3'(ct);
                bus_cycle(1'b0, io_addr(IO_ADC, 2'($urandom)), 3'd5, 2'($urandom), io_r,
                          16'($urandom), 0);
                @(posedge clk);
                joyana1 <= 16'($urandom);  // Reads must still see the latched pair
                joyana1b <= 16'($urandom);
                bus_cycle(1'b1, io_addr(IO_ADC, 2'($urandom)), 3'd5, 2'b00, io_r,
                          16'h0000, 0);
            end
        end
        end_test("ADC");

        finish_run();
    end

endmodule

`default_nettype wire
